// File: build.sh
#!/bin/sh
# Build and run the back-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_backend -f sim.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_backend > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

echo "Simulation passed"
exit 0

// File: common/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data memory size in words, must be a power of two
`define DMEM_WORDS 64

// Destination register for jump-and-link
`define LINK_REG 5'd31

`endif

// File: common/cpu_types_pkg.sv
`include "cpu_defs.svh"

package cpu_types_pkg;

	// Data and address word
	typedef logic [31:0] word_t;

	// Register file index
	typedef logic [4:0] regbits_t;

	// Word index into data memory
	typedef logic [$clog2(`DMEM_WORDS)-1:0] dmem_addr_t;

endpackage : cpu_types_pkg

// File: memwb/memwb.sv
module memwb (
	input  logic                    CLK,
	input  logic                    nRST,
	input  logic                    flush,
	input  logic                    write_en,
	input  cpu_types_pkg::word_t    load_data_in,
	input  cpu_types_pkg::word_t    alu_out_in,
	input  cpu_types_pkg::word_t    pcplus4_in,
	input  cpu_types_pkg::regbits_t rt_in,
	input  cpu_types_pkg::regbits_t rd_in,
	input  logic                    mem_to_reg_in,
	input  logic                    reg_dst_in,
	input  logic                    jtype_in,
	input  logic                    reg_wen_in,
	input  logic                    halt_in,
	output cpu_types_pkg::word_t    load_data,
	output cpu_types_pkg::word_t    alu_out,
	output cpu_types_pkg::word_t    pcplus4,
	output cpu_types_pkg::regbits_t rt,
	output cpu_types_pkg::regbits_t rd,
	output logic                    mem_to_reg,
	output logic                    reg_dst,
	output logic                    jtype,
	output logic                    reg_wen,
	output logic                    halt
);

	cpu_types_pkg::word_t    next_load_data, next_alu_out, next_pcplus4;
	cpu_types_pkg::regbits_t next_rt, next_rd;
	logic next_mem_to_reg, next_reg_dst, next_jtype, next_reg_wen, next_halt;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			load_data  <= '0;
			alu_out    <= '0;
			pcplus4    <= '0;
			rt         <= '0;
			rd         <= '0;
			mem_to_reg <= 1'b0;
			reg_dst    <= 1'b0;
			jtype      <= 1'b0;
			reg_wen    <= 1'b0;
			halt       <= 1'b0;
		end else begin
			load_data  <= next_load_data;
			alu_out    <= next_alu_out;
			pcplus4    <= next_pcplus4;
			rt         <= next_rt;
			rd         <= next_rd;
			mem_to_reg <= next_mem_to_reg;
			reg_dst    <= next_reg_dst;
			jtype      <= next_jtype;
			reg_wen    <= next_reg_wen;
			halt       <= next_halt;
		end
	end

	always_comb begin
		// Hold by default
		next_load_data  = load_data;
		next_alu_out    = alu_out;
		next_pcplus4    = pcplus4;
		next_rt         = rt;
		next_rd         = rd;
		next_mem_to_reg = mem_to_reg;
		next_reg_dst    = reg_dst;
		next_jtype      = jtype;
		next_reg_wen    = reg_wen;
		next_halt       = halt;

		if (flush) begin
			// Bubble wins over a strobe
			next_load_data  = '0;
			next_alu_out    = '0;
			next_pcplus4    = '0;
			next_rt         = '0;
			next_rd         = '0;
			next_mem_to_reg = 1'b0;
			next_reg_dst    = 1'b0;
			next_jtype      = 1'b0;
			next_reg_wen    = 1'b0;
			next_halt       = 1'b0;
		end else if (write_en) begin
			next_load_data  = load_data_in;
			next_alu_out    = alu_out_in;
			next_pcplus4    = pcplus4_in;
			next_rt         = rt_in;
			next_rd         = rd_in;
			next_mem_to_reg = mem_to_reg_in;
			next_reg_dst    = reg_dst_in;
			next_jtype      = jtype_in;
			next_reg_wen    = reg_wen_in;
			next_halt       = halt_in;
		end
	end

	// Flushed slot shows up as a bubble one edge later
	a_flush_bubble: assert property (@(posedge CLK) disable iff (!nRST)
		flush |=> (!reg_wen && !halt && !jtype && alu_out == '0 && load_data == '0));

endmodule : memwb

// File: memwb/writeback_regfile.sv
`include "cpu_defs.svh"

module writeback_regfile (
	input  logic                    CLK,
	input  logic                    nRST,
	input  cpu_types_pkg::word_t    load_data,
	input  cpu_types_pkg::word_t    alu_out,
	input  cpu_types_pkg::word_t    pcplus4,
	input  cpu_types_pkg::regbits_t rt,
	input  cpu_types_pkg::regbits_t rd,
	input  logic                    mem_to_reg,
	input  logic                    reg_dst,
	input  logic                    jtype,
	input  logic                    reg_wen,
	input  cpu_types_pkg::regbits_t rd_addr,
	output logic                    wb_wen,
	output cpu_types_pkg::regbits_t wb_reg,
	output cpu_types_pkg::word_t    wb_data,
	output cpu_types_pkg::word_t    rd_data
);

	cpu_types_pkg::word_t regs [32];

	// Result select, link beats load beats ALU
	always_comb begin
		if (jtype) begin
			wb_data = pcplus4;
		end else if (mem_to_reg) begin
			wb_data = load_data;
		end else begin
			wb_data = alu_out;
		end
	end

	// Destination select
	always_comb begin
		if (jtype) begin
			wb_reg = `LINK_REG;
		end else if (reg_dst) begin
			wb_reg = rd;
		end else begin
			wb_reg = rt;
		end
	end

	// $zero never takes a write
	assign wb_wen = reg_wen && (wb_reg != '0);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_wen) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// No bypass, new value visible after the edge
	assign rd_data = regs[rd_addr];

	a_zero_reg: assert property (@(posedge CLK) disable iff (!nRST)
		(rd_addr == '0) |-> (rd_data == '0));

endmodule : writeback_regfile

// File: sim.f
+incdir+common
common/cpu_types_pkg.sv
verilog/dmem_stage.sv
memwb/memwb.sv
memwb/writeback_regfile.sv
verilog/backend_top.sv
verification/tb_backend.sv

// File: verification/backend_input.txt
# In: valid flush alu_out store_data pcplus4 rt rd mem_read mem_write mem_to_reg reg_dst jtype reg_wen halt rd_addr
# Expected before next edge: wb_wen wb_data halt rd_data
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 00  0 00000000 0 00000000
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 05  0 00000000 0 00000000
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 1f  0 00000000 0 00000000
# ALU to rd, ALU to rt, ALU aimed at r0
1 0 12345678 00000000 00400004 02 03 0 0 0 1 0 1 0 03  0 00000000 0 00000000
1 0 0000abcd 00000000 00400008 04 05 0 0 0 0 0 1 0 03  1 12345678 0 00000000
1 0 deadbeef 00000000 0040000c 06 00 0 0 0 1 0 1 0 03  1 0000abcd 0 12345678
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 04  0 deadbeef 0 0000abcd
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 00  0 deadbeef 0 00000000
# Two stores, then loads back from each address
1 0 00000010 cafef00d 00400010 06 07 0 1 0 0 0 0 0 00  0 deadbeef 0 00000000
1 0 00000014 0badf00d 00400014 06 07 0 1 0 0 0 0 0 03  0 00000010 0 12345678
1 0 00000010 00000000 00400018 07 00 1 0 1 0 0 1 0 07  0 00000014 0 00000000
1 0 00000014 00000000 0040001c 08 00 1 0 1 0 0 1 0 07  1 cafef00d 0 00000000
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 07  1 0badf00d 0 cafef00d
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 08  1 0badf00d 0 0badf00d
# Jump-and-link, then an ALU op killed by flush
1 0 00001234 00000000 00400024 09 0a 0 0 0 1 1 1 0 1f  1 0badf00d 0 00000000
1 1 11111111 00000000 00400028 00 0b 0 0 0 1 0 1 0 1f  1 00400024 0 00000000
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 1f  0 00000000 0 00400024
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 0b  0 00000000 0 00000000
# Halt holds until a flush
1 0 00000000 00000000 0040002c 00 00 0 0 0 0 0 0 1 00  0 00000000 0 00000000
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 1f  0 00000000 1 00400024
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 03  0 00000000 1 12345678
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 04  0 00000000 1 0000abcd
0 1 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 08  0 00000000 1 0badf00d
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 00  0 00000000 0 00000000
1 0 a5a5a5a5 00000000 00400030 00 0d 0 0 0 1 0 1 0 0d  0 00000000 0 00000000
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 0d  1 a5a5a5a5 0 00000000
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 0d  1 a5a5a5a5 0 a5a5a5a5
# Overwrite one word, the neighbour keeps its value
1 0 00000010 12121212 00400034 00 00 0 1 0 0 0 0 0 07  1 a5a5a5a5 0 cafef00d
1 0 00000014 00000000 00400038 0e 00 1 0 1 0 0 1 0 0e  0 00000010 0 00000000
1 0 00000010 00000000 0040003c 0f 00 1 0 1 0 0 1 0 0e  1 0badf00d 0 00000000
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 0e  1 12121212 0 0badf00d
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 0f  1 12121212 0 12121212
0 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 07  1 12121212 0 cafef00d
end

// File: verification/tb_backend.sv
`include "cpu_defs.svh"

module tb_backend;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 3;
	localparam int NUM_FIELDS   = 19;

	// One cycle of stimulus and the outputs expected just before the next edge
	typedef struct packed {
		logic                    valid;
		logic                    flush;
		cpu_types_pkg::word_t    alu_out;
		cpu_types_pkg::word_t    store_data;
		cpu_types_pkg::word_t    pcplus4;
		cpu_types_pkg::regbits_t rt;
		cpu_types_pkg::regbits_t rd;
		logic                    mem_read, mem_write, mem_to_reg, reg_dst;
		logic                    jtype, reg_wen, halt;
		cpu_types_pkg::regbits_t rd_addr;
		logic                    exp_wb_wen;
		cpu_types_pkg::word_t    exp_wb_data;
		logic                    exp_halt;
		cpu_types_pkg::word_t    exp_rd_data;
	} vector_t;

	logic CLK = 1'b0;
	logic nRST, flush, ex_valid;
	logic ex_mem_read, ex_mem_write, ex_mem_to_reg, ex_reg_dst, ex_jtype, ex_reg_wen, ex_halt;
	cpu_types_pkg::word_t    ex_alu_out, ex_store_data, ex_pcplus4;
	cpu_types_pkg::regbits_t ex_rt, ex_rd, rd_addr;
	logic                    wb_wen, halt;
	cpu_types_pkg::regbits_t wb_reg;
	cpu_types_pkg::word_t    wb_data, rd_data;

	vector_t vectors[$];
	logic    vectors_loaded = 1'b0;
	int      timeout_limit = 0;

	// Destination held by the latch, zero out of reset
	cpu_types_pkg::regbits_t exp_wb_reg = '0;

	backend_top i_dut (
		.CLK(CLK), .nRST(nRST), .flush(flush), .ex_valid(ex_valid),
		.ex_alu_out(ex_alu_out), .ex_store_data(ex_store_data), .ex_pcplus4(ex_pcplus4),
		.ex_rt(ex_rt), .ex_rd(ex_rd),
		.ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write), .ex_mem_to_reg(ex_mem_to_reg),
		.ex_reg_dst(ex_reg_dst), .ex_jtype(ex_jtype), .ex_reg_wen(ex_reg_wen),
		.ex_halt(ex_halt), .rd_addr(rd_addr),
		.wb_wen(wb_wen), .wb_reg(wb_reg), .wb_data(wb_data), .halt(halt), .rd_data(rd_data)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_word(input string name, input cpu_types_pkg::word_t expected,
			input cpu_types_pkg::word_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at time %0t: %s expected %h, got %h",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_reg(input string name, input cpu_types_pkg::regbits_t expected,
			input cpu_types_pkg::regbits_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at time %0t: %s expected %0d, got %0d",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at time %0t: %s expected %b, got %b",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	// Destination the latch holds after the edge that samples this vector
	function automatic cpu_types_pkg::regbits_t expected_dest(input vector_t v,
			input cpu_types_pkg::regbits_t held);
		if (v.flush) begin
			return '0;
		end else if (!v.valid) begin
			return held;
		end else if (v.jtype) begin
			return `LINK_REG;
		end else if (v.reg_dst) begin
			return v.rd;
		end
		return v.rt;
	endfunction

	task automatic apply_vector(input vector_t v);
		ex_valid      = v.valid;
		flush         = v.flush;
		ex_alu_out    = v.alu_out;
		ex_store_data = v.store_data;
		ex_pcplus4    = v.pcplus4;
		ex_rt         = v.rt;
		ex_rd         = v.rd;
		ex_mem_read   = v.mem_read;
		ex_mem_write  = v.mem_write;
		ex_mem_to_reg = v.mem_to_reg;
		ex_reg_dst    = v.reg_dst;
		ex_jtype      = v.jtype;
		ex_reg_wen    = v.reg_wen;
		ex_halt       = v.halt;
		rd_addr       = v.rd_addr;
	endtask

	task automatic load_vectors();
		int    fd;
		int    n;
		string line;
		bit    found_end;
		logic  f_valid, f_flush, f_mrd, f_mwr, f_m2r, f_rdst, f_jt, f_wen, f_halt;
		logic  f_exp_wen, f_exp_halt;
		cpu_types_pkg::word_t    f_alu, f_sdata, f_pc4, f_exp_wb, f_exp_rd;
		cpu_types_pkg::regbits_t f_rt, f_rd, f_ra;

		found_end = 1'b0;
		fd = $fopen("verification/backend_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the data file verification/backend_input.txt");
			abort_run();
		end
		while (!found_end) begin
			if ($fgets(line, fd) == 0) begin
				$display("Data file ends before its end marker, stimulus is incomplete");
				abort_run();
			end
			// Blank lines and comments carry no vector
			if (line.len() >= 2 && line.getc(0) != "#") begin
				if (line.substr(0, 2) == "end") begin
					found_end = 1'b1;
				end else begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f_valid, f_flush, f_alu, f_sdata, f_pc4, f_rt, f_rd,
						f_mrd, f_mwr, f_m2r, f_rdst, f_jt, f_wen, f_halt, f_ra,
						f_exp_wen, f_exp_wb, f_exp_halt, f_exp_rd);
					if (n != NUM_FIELDS) begin
						$display("Data file line has %0d fields instead of %0d: %s",
							n, NUM_FIELDS, line);
						abort_run();
					end
					vectors.push_back('{f_valid, f_flush, f_alu, f_sdata, f_pc4, f_rt, f_rd,
						f_mrd, f_mwr, f_m2r, f_rdst, f_jt, f_wen, f_halt, f_ra,
						f_exp_wen, f_exp_wb, f_exp_halt, f_exp_rd});
				end
			end
		end
		$fclose(fd);
		if (vectors.size() == 0) begin
			$display("Data file holds no vectors");
			abort_run();
		end
	endtask

	initial begin
		nRST = 1'b0;
		apply_vector('0);
		load_vectors();
		timeout_limit = (2 * vectors.size() + RESET_CYCLES) * CLK_PERIOD;
		vectors_loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge CLK);
		#1 nRST = 1'b1;

		// Drive after the edge, sample one unit before the next one
		foreach (vectors[i]) begin
			@(posedge CLK);
			#1;
			apply_vector(vectors[i]);
			#2;
			check_bit("wb_wen", vectors[i].exp_wb_wen, wb_wen);
			check_word("wb_data", vectors[i].exp_wb_data, wb_data);
			check_reg("wb_reg", exp_wb_reg, wb_reg);
			check_bit("halt", vectors[i].exp_halt, halt);
			check_word("rd_data", vectors[i].exp_rd_data, rd_data);
			exp_wb_reg = expected_dest(vectors[i], exp_wb_reg);
		end

		$display("TEST OK");
		$finish;
	end

	initial begin
		wait (vectors_loaded);
		#(timeout_limit);
		$display("Timeout: run did not finish within %0d time units", timeout_limit);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule : tb_backend

// File: verilog/backend_top.sv
module backend_top (
	input  logic                    CLK,
	input  logic                    nRST,
	input  logic                    flush,
	input  logic                    ex_valid,
	input  cpu_types_pkg::word_t    ex_alu_out,
	input  cpu_types_pkg::word_t    ex_store_data,
	input  cpu_types_pkg::word_t    ex_pcplus4,
	input  cpu_types_pkg::regbits_t ex_rt,
	input  cpu_types_pkg::regbits_t ex_rd,
	input  logic                    ex_mem_read,
	input  logic                    ex_mem_write,
	input  logic                    ex_mem_to_reg,
	input  logic                    ex_reg_dst,
	input  logic                    ex_jtype,
	input  logic                    ex_reg_wen,
	input  logic                    ex_halt,
	input  cpu_types_pkg::regbits_t rd_addr,
	output logic                    wb_wen,
	output cpu_types_pkg::regbits_t wb_reg,
	output cpu_types_pkg::word_t    wb_data,
	output logic                    halt,
	output cpu_types_pkg::word_t    rd_data
);

	// Memory stage to latch
	cpu_types_pkg::word_t    m_load_data, m_alu_out, m_pcplus4;
	cpu_types_pkg::regbits_t m_rt, m_rd;
	logic m_mem_to_reg, m_reg_dst, m_jtype, m_reg_wen, m_halt, m_latch_en;

	// Latch to write-back
	cpu_types_pkg::word_t    w_load_data, w_alu_out, w_pcplus4;
	cpu_types_pkg::regbits_t w_rt, w_rd;
	logic w_mem_to_reg, w_reg_dst, w_jtype, w_reg_wen;

	dmem_stage i_dmem (
		.CLK(CLK), .nRST(nRST), .valid(ex_valid),
		.mem_read(ex_mem_read), .mem_write(ex_mem_write),
		.mem_to_reg_in(ex_mem_to_reg), .reg_dst_in(ex_reg_dst), .jtype_in(ex_jtype),
		.reg_wen_in(ex_reg_wen), .halt_in(ex_halt),
		.alu_out_in(ex_alu_out), .store_data(ex_store_data), .pcplus4_in(ex_pcplus4),
		.rt_in(ex_rt), .rd_in(ex_rd),
		.load_data(m_load_data), .alu_out(m_alu_out), .pcplus4(m_pcplus4),
		.rt(m_rt), .rd(m_rd),
		.mem_to_reg(m_mem_to_reg), .reg_dst(m_reg_dst), .jtype(m_jtype),
		.reg_wen(m_reg_wen), .halt(m_halt), .latch_en(m_latch_en)
	);

	memwb i_memwb (
		.CLK(CLK), .nRST(nRST), .flush(flush), .write_en(m_latch_en),
		.load_data_in(m_load_data), .alu_out_in(m_alu_out), .pcplus4_in(m_pcplus4),
		.rt_in(m_rt), .rd_in(m_rd),
		.mem_to_reg_in(m_mem_to_reg), .reg_dst_in(m_reg_dst), .jtype_in(m_jtype),
		.reg_wen_in(m_reg_wen), .halt_in(m_halt),
		.load_data(w_load_data), .alu_out(w_alu_out), .pcplus4(w_pcplus4),
		.rt(w_rt), .rd(w_rd),
		.mem_to_reg(w_mem_to_reg), .reg_dst(w_reg_dst), .jtype(w_jtype),
		.reg_wen(w_reg_wen), .halt(halt)
	);

	writeback_regfile i_wb (
		.CLK(CLK), .nRST(nRST),
		.load_data(w_load_data), .alu_out(w_alu_out), .pcplus4(w_pcplus4),
		.rt(w_rt), .rd(w_rd),
		.mem_to_reg(w_mem_to_reg), .reg_dst(w_reg_dst), .jtype(w_jtype),
		.reg_wen(w_reg_wen), .rd_addr(rd_addr),
		.wb_wen(wb_wen), .wb_reg(wb_reg), .wb_data(wb_data), .rd_data(rd_data)
	);

endmodule : backend_top

// File: verilog/dmem_stage.sv
`include "cpu_defs.svh"

module dmem_stage (
	input  logic                    CLK,
	input  logic                    nRST,
	input  logic                    valid,
	input  logic                    mem_read,
	input  logic                    mem_write,
	input  logic                    mem_to_reg_in,
	input  logic                    reg_dst_in,
	input  logic                    jtype_in,
	input  logic                    reg_wen_in,
	input  logic                    halt_in,
	input  cpu_types_pkg::word_t    alu_out_in,
	input  cpu_types_pkg::word_t    store_data,
	input  cpu_types_pkg::word_t    pcplus4_in,
	input  cpu_types_pkg::regbits_t rt_in,
	input  cpu_types_pkg::regbits_t rd_in,
	output cpu_types_pkg::word_t    load_data,
	output cpu_types_pkg::word_t    alu_out,
	output cpu_types_pkg::word_t    pcplus4,
	output cpu_types_pkg::regbits_t rt,
	output cpu_types_pkg::regbits_t rd,
	output logic                    mem_to_reg,
	output logic                    reg_dst,
	output logic                    jtype,
	output logic                    reg_wen,
	output logic                    halt,
	output logic                    latch_en
);

	localparam int ADDR_W = $bits(cpu_types_pkg::dmem_addr_t);

	cpu_types_pkg::word_t     mem [`DMEM_WORDS];
	cpu_types_pkg::dmem_addr_t word_idx;

	// Byte address to word index, low two bits dropped
	assign word_idx = alu_out_in[ADDR_W+1:2];

	// Store lands on the edge that samples the strobe
	always_ff @(posedge CLK) begin
		if (valid && mem_write) begin
			mem[word_idx] <= store_data;
		end
	end

	// Combinational load
	assign load_data = (valid && mem_read) ? mem[word_idx] : '0;

	// Payload passes straight on to the latch
	assign alu_out = alu_out_in;
	assign pcplus4 = pcplus4_in;
	assign rt      = rt_in;
	assign rd      = rd_in;

	// Controls only count with a strobe
	assign mem_to_reg = valid & mem_to_reg_in;
	assign reg_dst    = valid & reg_dst_in;
	assign jtype      = valid & jtype_in;
	assign reg_wen    = valid & reg_wen_in;
	assign halt       = valid & halt_in;
	assign latch_en   = valid;

	// A load and a store never share one instruction
	a_no_rd_wr: assert property (@(posedge CLK) disable iff (!nRST)
		valid |-> !(mem_read && mem_write));

	// Word access only
	a_aligned: assert property (@(posedge CLK) disable iff (!nRST)
		(valid && (mem_read || mem_write)) |-> (alu_out_in[1:0] == 2'b00));

endmodule : dmem_stage
